//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] cpuWord;
    typedef logic [4:0] regIndex;

    localparam cpuWord resetVector = 32'hBFC0_0000;
    localparam cpuWord haltAddress = 32'h0000_0000;   // fetching here stops the core
    localparam regIndex linkRegister = 5'd31;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opCode;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } fnCode;

    // rt field of the REGIMM group
    typedef enum logic [4:0] {
        brBltz   = 5'b00000,
        brBgez   = 5'b00001,
        brBltzal = 5'b10000,
        brBgezal = 5'b10001
    } branchCode;

    typedef enum logic [3:0] {
        aluAnd, aluOr, aluXor, aluLui,
        aluAdd, aluSub, aluSlt, aluSltu,
        aluPassA, aluSll, aluSrl, aluSra,
        aluSllv, aluSrlv, aluSrav
    } aluOp;

    typedef enum logic [2:0] {
        stFetch     = 3'b000,
        stDecode    = 3'b001,
        stExecute   = 3'b010,
        stMemory    = 3'b011,
        stWriteback = 3'b100,
        stHalted    = 3'b111
    } cpuState;

endpackage

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu (
    input cpuPkg::aluOp operation,
    input cpuPkg::cpuWord a,
    input cpuPkg::cpuWord b,
    input logic [4:0] shiftAmount,
    output cpuPkg::cpuWord result,
    output logic zero
);
    import cpuPkg::*;

    always_comb begin
        case (operation)
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluXor: result = a ^ b;
            aluLui: result = {b[15:0], 16'b0};
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluSlt: result = {31'b0, $signed(a) < $signed(b)};
            aluSltu: result = {31'b0, a < b};
            aluPassA: result = a;
            aluSll: result = b << shiftAmount;
            aluSrl: result = b >> shiftAmount;
            aluSra: result = $signed(b) >>> shiftAmount;
            // variable shifts take the amount from rs
            aluSllv: result = b << a[4:0];
            aluSrlv: result = b >> a[4:0];
            aluSrav: result = $signed(b) >>> a[4:0];
            default: result = '0;
        endcase
    end

    assign zero = result == '0;   // beq/bne and blez/bgtz use this

endmodule

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

module registerFile (
    input logic clk,
    input logic reset,
    input logic writeEnable,
    input cpuPkg::regIndex writeIndex,
    input cpuPkg::cpuWord writeData,
    input cpuPkg::regIndex readA,
    input cpuPkg::regIndex readB,
    output cpuPkg::cpuWord dataA,
    output cpuPkg::cpuWord dataB,
    output cpuPkg::cpuWord registerV0
);
    import cpuPkg::*;

    cpuWord regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;   // $zero never written
        end
    end

    assign dataA = (readA == '0) ? '0 : regs[readA];
    assign dataB = (readB == '0) ? '0 : regs[readB];
    assign registerV0 = regs[2];

endmodule

`default_nettype wire

//--- source/programCounter.sv
`default_nettype none

module programCounter (
    input logic clk,
    input logic reset,
    input cpuPkg::cpuState state,
    input logic branchTaken,
    input logic jumpTaken,
    input cpuPkg::cpuWord jumpTarget,
    input cpuPkg::cpuWord branchOffset,
    output cpuPkg::cpuWord pc
);
    import cpuPkg::*;

    cpuWord target;     // pending destination
    cpuWord pcNext;
    logic recorded;     // this instruction redirects
    logic inDelaySlot;  // next writeback loads the target

    assign pcNext = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (state == stExecute && jumpTaken) begin
            target <= jumpTarget;
        end else if (state == stMemory && branchTaken) begin
            target <= pcNext + {branchOffset[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            recorded <= 1'b0;
            inDelaySlot <= 1'b0;
        end else if (state == stWriteback) begin
            // the delay slot runs first, then the target
            pc <= inDelaySlot ? target : pcNext;
            inDelaySlot <= recorded;
            recorded <= 1'b0;
        end else if ((state == stExecute && jumpTaken) || (state == stMemory && branchTaken)) begin
            recorded <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input logic clk,
    input logic reset,
    input cpuPkg::cpuState state,
    input cpuPkg::cpuWord pc,
    input cpuPkg::cpuWord readdata,
    input cpuPkg::cpuWord aluResult,
    input logic aluZero,
    output cpuPkg::regIndex readA,
    output cpuPkg::regIndex readB,
    output cpuPkg::aluOp operation,
    output cpuPkg::cpuWord immediate,
    output logic [4:0] shiftAmount,
    output logic useImmediate,
    output logic memRead,
    output logic memWrite,
    output logic branchTaken,
    output logic jumpTaken,
    output cpuPkg::cpuWord jumpTarget,
    output logic regWrite,
    output cpuPkg::regIndex writeIndex,
    output logic [1:0] writeSelect
);
    import cpuPkg::*;

    cpuWord instruction;
    cpuWord delaySlotPc;
    opCode op;
    fnCode fn;
    branchCode rtCode;
    logic registerJump;
    logic regimmLink;
    logic linking;
    logic writesRegister;
    logic condition;

    always_ff @(posedge clk) begin
        if (reset) begin
            instruction <= '0;   // reads as a nop
        end else if (state == stDecode) begin
            instruction <= readdata;
        end
    end

    assign op = opCode'(instruction[31:26]);
    assign fn = fnCode'(instruction[5:0]);
    assign rtCode = branchCode'(instruction[20:16]);

    assign readA = instruction[25:21];
    assign readB = instruction[20:16];
    assign shiftAmount = instruction[10:6];

    // logic immediates zero-extend, the rest sign-extend
    assign immediate = (op == opAndi || op == opOri || op == opXori)
                     ? {16'b0, instruction[15:0]}
                     : {{16{instruction[15]}}, instruction[15:0]};

    always_comb begin
        operation = aluAdd;
        useImmediate = 1'b0;
        writesRegister = 1'b0;
        case (op)
            opSpecial: begin
                writesRegister = 1'b1;
                case (fn)
                    fnSll: operation = aluSll;
                    fnSrl: operation = aluSrl;
                    fnSra: operation = aluSra;
                    fnSllv: operation = aluSllv;
                    fnSrlv: operation = aluSrlv;
                    fnSrav: operation = aluSrav;
                    fnAddu: operation = aluAdd;
                    fnSubu: operation = aluSub;
                    fnAnd: operation = aluAnd;
                    fnOr: operation = aluOr;
                    fnXor: operation = aluXor;
                    fnSlt: operation = aluSlt;
                    fnSltu: operation = aluSltu;
                    fnJalr: operation = aluPassA;   // target is rs, rd gets the link
                    fnJr: begin
                        operation = aluPassA;
                        writesRegister = 1'b0;
                    end
                    default: writesRegister = 1'b0;
                endcase
            end
            opRegimm, opBlez, opBgtz: operation = aluPassA;   // rs against zero
            opBeq, opBne: operation = aluSub;
            opSw: useImmediate = 1'b1;
            default: begin
                useImmediate = 1'b1;
                writesRegister = op != opJ && op != opJal;
                case (op)
                    opSlti: operation = aluSlt;
                    opSltiu: operation = aluSltu;
                    opAndi: operation = aluAnd;
                    opOri: operation = aluOr;
                    opXori: operation = aluXor;
                    opLui: operation = aluLui;
                    default: operation = aluAdd;   // addiu, lw
                endcase
            end
        endcase
    end

    always_comb begin
        case (op)
            opBeq: condition = aluZero;
            opBne: condition = !aluZero;
            opBlez: condition = aluResult[31] || aluZero;
            opBgtz: condition = !aluResult[31] && !aluZero;
            opRegimm: begin
                case (rtCode)
                    brBltz, brBltzal: condition = aluResult[31];
                    brBgez, brBgezal: condition = !aluResult[31];
                    default: condition = 1'b0;
                endcase
            end
            default: condition = 1'b0;
        endcase
    end

    assign registerJump = op == opSpecial && (fn == fnJr || fn == fnJalr);
    assign regimmLink = op == opRegimm && (rtCode == brBltzal || rtCode == brBgezal);
    assign linking = op == opJal || regimmLink || (op == opSpecial && fn == fnJalr);

    assign branchTaken = state == stMemory && condition;
    assign jumpTaken = state == stExecute && (op == opJ || op == opJal || registerJump);

    // J and JAL stay in the 256 MB region of the delay slot
    assign delaySlotPc = pc + 32'd4;
    assign jumpTarget = registerJump ? aluResult
                                     : {delaySlotPc[31:28], instruction[25:0], 2'b00};

    assign memRead = op == opLw;
    assign memWrite = op == opSw;

    // linking branches write $ra whether taken or not
    assign regWrite = state == stWriteback && (writesRegister || linking);
    assign writeIndex = (op == opJal || regimmLink) ? linkRegister :
                        (op == opSpecial) ? instruction[15:11] :
                        instruction[20:16];
    assign writeSelect = {linking, op == opLw};

endmodule

`default_nettype wire

//--- source/cpuControl.sv
`default_nettype none

module cpuControl (
    input logic clk,
    input logic reset,
    input logic waitrequest,
    input logic memRead,
    input logic memWrite,
    input cpuPkg::cpuWord pcAddress,
    output cpuPkg::cpuState state,
    output logic active,
    output logic read,
    output logic write
);
    import cpuPkg::*;

    logic dataAccess;
    logic haltFetch;

    assign dataAccess = memRead || memWrite;
    assign haltFetch = pcAddress == haltAddress;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            case (state)
                stFetch: begin
                    if (haltFetch) begin
                        state <= stHalted;
                    end else if (!waitrequest) begin
                        state <= stDecode;   // instruction arrives next cycle
                    end
                end
                stDecode: state <= stExecute;
                stExecute: state <= stMemory;
                stMemory: begin
                    // only a pending load or store waits on the bus
                    if (!(dataAccess && waitrequest)) begin
                        state <= stWriteback;
                    end
                end
                stWriteback: state <= stFetch;
                default: state <= stHalted;   // halted until reset
            endcase
        end
    end

    assign active = state != stHalted;

    // no bus cycle is started for the halt address
    assign read = (state == stFetch && !haltFetch) || (state == stMemory && memRead);
    assign write = state == stMemory && memWrite;

endmodule

`default_nettype wire

//--- source/mipsCpuBus.sv
`default_nettype none

module mipsCpuBus (
    input logic clk,
    input logic reset,
    output logic active,
    output cpuPkg::cpuWord registerV0,
    output cpuPkg::cpuWord address,
    output logic read,
    output logic write,
    output cpuPkg::cpuWord writedata,
    input cpuPkg::cpuWord readdata,
    input logic waitrequest
);
    import cpuPkg::*;

    // memory holds words big-endian, registers little-endian
    function automatic cpuWord byteSwap(input cpuWord value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    cpuState state;
    cpuWord pc;
    regIndex readA;
    regIndex readB;
    regIndex writeIndex;
    aluOp operation;
    cpuWord immediate;
    cpuWord dataA;
    cpuWord dataB;
    cpuWord aluB;
    cpuWord aluResult;
    cpuWord jumpTarget;
    cpuWord writeData;
    cpuWord busAddress;
    logic [4:0] shiftAmount;
    logic [1:0] writeSelect;   // {link, load}
    logic useImmediate;
    logic memRead;
    logic memWrite;
    logic branchTaken;
    logic jumpTaken;
    logic regWrite;
    logic aluZero;

    assign busAddress = (state == stFetch) ? pc : aluResult;
    assign address = {busAddress[31:2], 2'b00};   // word accesses only
    assign writedata = byteSwap(dataB);

    assign aluB = useImmediate ? immediate : dataB;

    assign writeData = writeSelect[1] ? pc + 32'd8 :        // return address past the delay slot
                       writeSelect[0] ? byteSwap(readdata) :
                       aluResult;

    cpuControl control (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .memRead(memRead),
        .memWrite(memWrite),
        .pcAddress(pc),
        .state(state),
        .active(active),
        .read(read),
        .write(write)
    );

    instrDecoder decoder (
        .clk(clk),
        .reset(reset),
        .state(state),
        .pc(pc),
        .readdata(readdata),
        .aluResult(aluResult),
        .aluZero(aluZero),
        .readA(readA),
        .readB(readB),
        .operation(operation),
        .immediate(immediate),
        .shiftAmount(shiftAmount),
        .useImmediate(useImmediate),
        .memRead(memRead),
        .memWrite(memWrite),
        .branchTaken(branchTaken),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .regWrite(regWrite),
        .writeIndex(writeIndex),
        .writeSelect(writeSelect)
    );

    programCounter programCount (
        .clk(clk),
        .reset(reset),
        .state(state),
        .branchTaken(branchTaken),
        .jumpTaken(jumpTaken),
        .jumpTarget(jumpTarget),
        .branchOffset(immediate),
        .pc(pc)
    );

    registerFile registers (
        .clk(clk),
        .reset(reset),
        .writeEnable(regWrite),
        .writeIndex(writeIndex),
        .writeData(writeData),
        .readA(readA),
        .readB(readB),
        .dataA(dataA),
        .dataB(dataB),
        .registerV0(registerV0)
    );

    alu arith (
        .operation(operation),
        .a(dataA),
        .b(aluB),
        .shiftAmount(shiftAmount),
        .result(aluResult),
        .zero(aluZero)
    );

endmodule

`default_nettype wire

//--- testbench/busMemory.sv
`default_nettype none

module busMemory (
    input logic clk,
    input cpuPkg::cpuWord address,
    input logic read,
    input logic write,
    input cpuPkg::cpuWord writedata,
    output cpuPkg::cpuWord readdata,
    output logic waitrequest,
    input logic stall,
    input logic loadEnable,
    input cpuPkg::cpuWord loadAddress,
    input cpuPkg::cpuWord loadData
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    // 4 KB window that ignores the upper address bits
    // data words stay in bus order and so are byte-reversed against the registers
    cpuWord words [1024];

    assign waitrequest = stall;   // stall pattern comes from the test top

    always_ff @(posedge clk) begin
        if (loadEnable) begin
            words[loadAddress[11:2]] <= loadData;   // program loading bypasses the bus
        end else if (write && !waitrequest) begin
            words[address[11:2]] <= writedata;
        end
        // read data shows up in the cycle after the accepted read
        if (read && !waitrequest) begin
            readdata <= words[address[11:2]];
        end
    end

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    typedef enum {
        kAddu, kSubu, kAnd, kOr, kXor, kSlt, kSltu, kSll, kSrl, kSra, kSllv, kSrlv, kSrav,
        kAddiu, kAndi, kOri, kXori, kSlti, kSltiu, kLui,
        kStoreLoad,
        kBeq, kBne, kBlez, kBgtz, kBltz, kBgez, kBgezal, kJ, kJal, kJalr
    } testKind;

    typedef struct {
        testKind kind;
        cpuWord a;
        cpuWord b;
        cpuWord expected;
    } testEntry;

    localparam cpuWord seed = 32'h4710;
    localparam int programLength = 10;                          // longest program in words
    localparam cpuWord targetAddress = resetVector + 32'd28;   // word 7 of the program
    localparam cpuWord linkValue = resetVector + 32'd24;       // jump sits at word 4

    logic clk = 1'b0;
    logic reset;
    logic stall = 1'b0;
    logic active;
    logic read;
    logic write;
    logic waitrequest;
    logic loadEnable;
    cpuWord loadAddress;
    cpuWord loadData;
    cpuWord registerV0;
    cpuWord address;
    cpuWord writedata;
    cpuWord readdata;
    cpuWord storedWord;
    cpuWord storedAddress;
    cpuWord stallState = seed;
    cpuWord programWords [$];
    testEntry tests [$];
    int cycleCount = 0;
    int cycleLimit;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;

    mipsCpuBus mipsCpuBus_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .registerV0(registerV0),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .readdata(readdata),
        .waitrequest(waitrequest)
    );

    busMemory memoryModel (
        .clk(clk),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .readdata(readdata),
        .waitrequest(waitrequest),
        .stall(stall),
        .loadEnable(loadEnable),
        .loadAddress(loadAddress),
        .loadData(loadData)
    );

    always #2 clk = ~clk;

    function automatic cpuWord xorshift(input cpuWord x);
        cpuWord y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    always @(posedge clk) begin
        stallState <= xorshift(stallState);
        stall <= stallState[1:0] == 2'b00;   // about one cycle in four
    end

    // what the bus carried on the last accepted store
    always @(posedge clk) begin
        if (reset) begin
            storedWord <= '0;
            storedAddress <= '0;
        end else if (write && !waitrequest) begin
            storedWord <= writedata;
            storedAddress <= address;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic cpuWord encodeR(fnCode fn, regIndex rs, regIndex rt, regIndex rd,
                                       logic [4:0] sa);
        return {opSpecial, rs, rt, rd, sa, fn};
    endfunction

    function automatic cpuWord encodeI(opCode op, regIndex rs, regIndex rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuWord encodeJ(opCode op, cpuWord target);
        return {op, target[27:2]};
    endfunction

    function automatic cpuWord reverseBytes(cpuWord w);
        cpuWord r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return r;
    endfunction

    function automatic logic linking(testKind kind);
        return kind == kJal || kind == kJalr || kind == kBgezal;
    endfunction

    function automatic logic takesBranch(testKind kind, cpuWord a, cpuWord b);
        case (kind)
            kBeq: return a == b;
            kBne: return a != b;
            kBlez: return $signed(a) <= 0;
            kBgtz: return $signed(a) > 0;
            kBltz: return a[31];
            kBgez, kBgezal: return !a[31];
            default: return 1'b1;   // j, jal, jalr
        endcase
    endfunction

    function automatic cpuWord expectedV0(testKind kind, cpuWord a, cpuWord b);
        cpuWord immSigned;
        cpuWord immZero;
        cpuWord sum;
        immSigned = {{16{b[15]}}, b[15:0]};
        immZero = {16'h0000, b[15:0]};
        case (kind)
            kAddu: return a + b;
            kSubu: return a - b;
            kAnd: return a & b;
            kOr: return a | b;
            kXor: return a ^ b;
            kSlt: return {31'b0, $signed(a) < $signed(b)};
            kSltu: return {31'b0, a < b};
            kSll: return b << a[9:5];   // sa field of the instruction
            kSrl: return b >> a[9:5];
            kSra: return $signed(b) >>> a[9:5];
            kSllv: return b << a[4:0];   // low bits of rs
            kSrlv: return b >> a[4:0];
            kSrav: return $signed(b) >>> a[4:0];
            kAddiu: return a + immSigned;
            kAndi: return a & immZero;
            kOri: return a | immZero;
            kXori: return a ^ immZero;
            kSlti: return {31'b0, $signed(a) < $signed(immSigned)};
            kSltiu: return {31'b0, a < immSigned};
            kLui: return {b[15:0], 16'h0000};
            kStoreLoad: return b;
            default: begin
                // delay slot adds 1, skipped word 2, target 4 or the link value
                sum = 32'd1;
                if (!takesBranch(kind, a, b)) begin
                    sum += 32'd2;
                end
                sum += linking(kind) ? linkValue : 32'd4;
                return sum;
            end
        endcase
    endfunction

    function automatic fnCode aluFunction(testKind kind);
        case (kind)
            kSubu: return fnSubu;
            kAnd: return fnAnd;
            kOr: return fnOr;
            kXor: return fnXor;
            kSlt: return fnSlt;
            kSltu: return fnSltu;
            kSll: return fnSll;
            kSrl: return fnSrl;
            kSra: return fnSra;
            kSllv: return fnSllv;
            kSrlv: return fnSrlv;
            kSrav: return fnSrav;
            default: return fnAddu;
        endcase
    endfunction

    function automatic opCode immediateOpcode(testKind kind);
        case (kind)
            kAndi: return opAndi;
            kOri: return opOri;
            kXori: return opXori;
            kSlti: return opSlti;
            kSltiu: return opSltiu;
            kLui: return opLui;
            default: return opAddiu;
        endcase
    endfunction

    // branch offset 2 lands on word 7 past the skipped word
    function automatic cpuWord controlInstruction(testKind kind);
        case (kind)
            kBeq: return encodeI(opBeq, 5'd8, 5'd9, 16'd2);
            kBne: return encodeI(opBne, 5'd8, 5'd9, 16'd2);
            kBlez: return encodeI(opBlez, 5'd8, 5'd0, 16'd2);
            kBgtz: return encodeI(opBgtz, 5'd8, 5'd0, 16'd2);
            kBltz: return encodeI(opRegimm, 5'd8, regIndex'(brBltz), 16'd2);
            kBgez: return encodeI(opRegimm, 5'd8, regIndex'(brBgez), 16'd2);
            kBgezal: return encodeI(opRegimm, 5'd8, regIndex'(brBgezal), 16'd2);
            kJ: return encodeJ(opJ, targetAddress);
            kJal: return encodeJ(opJal, targetAddress);
            default: return encodeR(fnJalr, 5'd8, 5'd0, linkRegister, 5'd0);
        endcase
    endfunction

    task automatic buildProgram(testEntry t);
        programWords.delete();
        // operand a in $8, operand b in $9
        programWords.push_back(encodeI(opLui, 5'd0, 5'd8, t.a[31:16]));
        programWords.push_back(encodeI(opOri, 5'd8, 5'd8, t.a[15:0]));
        programWords.push_back(encodeI(opLui, 5'd0, 5'd9, t.b[31:16]));
        programWords.push_back(encodeI(opOri, 5'd9, 5'd9, t.b[15:0]));
        if (t.kind <= kSrav) begin
            // sa field differs from the low bits of rs
            programWords.push_back(encodeR(aluFunction(t.kind), 5'd8, 5'd9, 5'd2, t.a[9:5]));
        end else if (t.kind <= kLui) begin
            programWords.push_back(encodeI(immediateOpcode(t.kind), 5'd8, 5'd2, t.b[15:0]));
        end else if (t.kind == kStoreLoad) begin
            programWords.push_back(encodeI(opSw, 5'd8, 5'd9, 16'd0));
            programWords.push_back(encodeI(opLw, 5'd8, 5'd2, 16'd0));
        end else begin
            programWords.push_back(controlInstruction(t.kind));
            programWords.push_back(encodeI(opAddiu, 5'd2, 5'd2, 16'd1));   // delay slot
            programWords.push_back(encodeI(opAddiu, 5'd2, 5'd2, 16'd2));   // skipped if taken
            if (linking(t.kind)) begin
                programWords.push_back(encodeR(fnAddu, 5'd2, linkRegister, 5'd2, 5'd0));
            end else begin
                programWords.push_back(encodeI(opAddiu, 5'd2, 5'd2, 16'd4));
            end
        end
        programWords.push_back(encodeR(fnJr, 5'd0, 5'd0, 5'd0, 5'd0));
        programWords.push_back(32'h0000_0000);   // nop in the last delay slot
    endtask

    task automatic buildTable();
        testEntry entry;
        cpuWord randomState;
        cpuWord firstA;
        testKind kind;
        randomState = seed;
        kind = kind.first();
        repeat (kind.num()) begin
            for (int v = 0; v < 3; v++) begin
                randomState = xorshift(randomState);
                entry.a = randomState;
                randomState = xorshift(randomState);
                entry.b = randomState;
                if (v == 0) begin
                    firstA = entry.a;
                end else if (v == 1) begin
                    entry.a = {~firstA[31], firstA[30:0]};   // equal operands of the other sign
                    entry.b = entry.a;
                end else begin
                    entry.a = '0;
                end
                if (kind == kJalr) begin
                    entry.a = targetAddress;
                end
                if (kind == kStoreLoad) begin
                    entry.a = 32'h0000_0400 | (randomState & 32'h0000_03FC);
                end
                entry.kind = kind;
                entry.expected = expectedV0(kind, entry.a, entry.b);
                tests.push_back(entry);
            end
            kind = kind.next();
        end
    endtask

    task automatic checkWord(string what, cpuWord got, cpuWord want);
        if (got !== want) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
            errorCount++;
        end
    endtask

    task automatic checkActive(string what, logic got, logic want);
        if (got !== want) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
            errorCount++;
        end
    endtask

    task automatic runTest(int number, testEntry t);
        int errorsBefore;
        errorsBefore = errorCount;
        buildProgram(t);
        @(posedge clk);
        // the core sits halted from the previous test while the program loads
        foreach (programWords[i]) begin
            loadEnable <= 1'b1;
            loadAddress <= resetVector + cpuWord'(4 * i);
            loadData <= programWords[i];
            @(posedge clk);
        end
        loadEnable <= 1'b0;
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkActive("active after reset", active, 1'b1);
        checkActive("fetch read after reset", read, 1'b1);
        checkActive("write after reset", write, 1'b0);
        while (active === 1'b1) @(negedge clk);
        checkWord("v0", registerV0, t.expected);
        if (t.kind == kStoreLoad) begin
            checkWord("store address", storedAddress, t.a);
            checkWord("store data on the bus", storedWord, reverseBytes(t.b));
        end
        repeat (3) begin
            @(negedge clk);
            checkActive("active after halt", active, 1'b0);
            checkActive("read after halt", read, 1'b0);
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d %s a=%h b=%h: ok", number, t.kind.name(), t.a, t.b);
        end else begin
            failCount++;
            $display("test %0d %s a=%h b=%h: wrong", number, t.kind.name(), t.a, t.b);
        end
    endtask

    initial begin
        reset <= 1'b1;
        loadEnable <= 1'b0;
        loadAddress <= '0;
        loadData <= '0;
        buildTable();
        cycleLimit = tests.size() * programLength * 5 * 4;
        foreach (tests[n]) begin
            runTest(n, tests[n]);
        end
        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/cpuPkg.sv
source/alu.sv
source/registerFile.sv
source/programCounter.sv
source/instrDecoder.sv
source/cpuControl.sv
source/mipsCpuBus.sv
testbench/busMemory.sv
testbench/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
